/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_attitude_offset
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
common/flight_pkg.sv
rtl/stick_band_decoder.sv
rtl/mix_table_lookup.sv
rtl/offset_output_reg.sv
rtl/attitude_offset_top.sv
verif/attitude_offset_properties.sv
verif/tb_attitude_offset.sv

/* common/flight_pkg.sv */
package flight_pkg;

	localparam int STICK_W         = 8;
	localparam int OFFSET_W        = 8;
	localparam int NUM_MOTORS      = 4;
	localparam int NUM_LEDS        = 8;
	localparam int NUM_THR_BANDS   = 5;
	localparam int NUM_ZONES       = 3;
	localparam int NUM_STICK_BANDS = 10;
	localparam int BAND_IDX_W      = 4;
	localparam int ZONE_IDX_W      = 2;

	// upper inclusive limits with band 4 above the last one
	localparam logic [STICK_W-1:0] THR_BAND_LIMITS [NUM_THR_BANDS-1] = '{
		8'd2, 8'd10, 8'd20, 8'd30
	};

	localparam logic [STICK_W-1:0] ZONE_IDLE_MAX = 8'd5; // attitude outputs hold at or below

	localparam logic [STICK_W-1:0] ZONE_LIMITS [NUM_ZONES-1] = '{
		8'd10, 8'd30
	};

	localparam logic [STICK_W-1:0] STICK_LIMITS [NUM_STICK_BANDS-1] = '{
		8'd5, 8'd10, 8'd15, 8'd18, 8'd22, 8'd25, 8'd30, 8'd35, 8'd38
	};

	// added to throttle per motor starting with motor 1
	localparam logic [OFFSET_W-1:0] THR_BASE_ADD [NUM_THR_BANDS][NUM_MOTORS] = '{
		'{8'd0,  8'd0,  8'd0,  8'd0},
		'{8'd2,  8'd8,  8'd6,  8'd7},
		'{8'd8,  8'd12, 8'd6,  8'd7},
		'{8'd13, 8'd16, 8'd14, 8'd15},
		'{8'd20, 8'd25, 8'd22, 8'd23}
	};

	// thermometer with led1 in bit 0
	localparam logic [NUM_LEDS-1:0] LED_PATTERN [NUM_THR_BANDS] = '{
		8'hff, 8'h7f, 8'h3f, 8'h1f, 8'h0f
	};

	// indexed by zone then stick band then motor
	localparam logic signed [OFFSET_W-1:0]
		PITCH_CORR [NUM_ZONES][NUM_STICK_BANDS][NUM_MOTORS] = '{
		'{ // low zone
			'{ 8'sd0,  8'sd10,  8'sd0,  8'sd12},
			'{ 8'sd0,  8'sd8,   8'sd0,  8'sd9},
			'{ 8'sd0,  8'sd4,   8'sd0,  8'sd6},
			'{ 8'sd0,  8'sd2,   8'sd0,  8'sd3},
			'{ 8'sd0,  8'sd0,   8'sd0,  8'sd0},
			'{ 8'sd3, -8'sd1,   8'sd3, -8'sd1},
			'{ 8'sd6, -8'sd2,   8'sd5, -8'sd2},
			'{ 8'sd9, -8'sd3,   8'sd7, -8'sd3},
			'{ 8'sd12, -8'sd4,  8'sd9, -8'sd4},
			'{ 8'sd15, -8'sd5,  8'sd11, -8'sd6}
		},
		'{ // mid zone
			'{-8'sd5,  8'sd4,  -8'sd6,  8'sd4},
			'{-8'sd3,  8'sd3,  -8'sd4,  8'sd3},
			'{-8'sd2,  8'sd2,  -8'sd2,  8'sd2},
			'{-8'sd1,  8'sd1,  -8'sd1,  8'sd1},
			'{ 8'sd0,  8'sd0,   8'sd0,  8'sd0},
			'{ 8'sd1, -8'sd1,   8'sd1, -8'sd1},
			'{ 8'sd2, -8'sd2,   8'sd2, -8'sd2},
			'{ 8'sd3, -8'sd4,   8'sd4, -8'sd4},
			'{ 8'sd4, -8'sd5,   8'sd6, -8'sd7},
			'{ 8'sd5, -8'sd7,   8'sd8, -8'sd10}
		},
		'{ // high zone
			'{-8'sd8,  8'sd0,  -8'sd8,  8'sd0},
			'{-8'sd6,  8'sd0,  -8'sd6,  8'sd0},
			'{-8'sd4,  8'sd0,  -8'sd4,  8'sd0},
			'{-8'sd2,  8'sd0,  -8'sd2,  8'sd0},
			'{ 8'sd0,  8'sd0,   8'sd0,  8'sd0},
			'{ 8'sd1, -8'sd1,   8'sd1, -8'sd1},
			'{ 8'sd2, -8'sd2,   8'sd2, -8'sd2},
			'{ 8'sd3, -8'sd4,   8'sd3, -8'sd4},
			'{ 8'sd5, -8'sd6,   8'sd4, -8'sd6},
			'{ 8'sd7, -8'sd8,   8'sd5, -8'sd8}
		}
	};

	localparam logic signed [OFFSET_W-1:0]
		ROLL_CORR [NUM_ZONES][NUM_STICK_BANDS][NUM_MOTORS] = '{
		'{ // low zone
			'{ 8'sd0,  8'sd11,  8'sd10,  8'sd0},
			'{ 8'sd0,  8'sd8,   8'sd7,   8'sd0},
			'{ 8'sd0,  8'sd6,   8'sd5,   8'sd0},
			'{ 8'sd0,  8'sd3,   8'sd2,   8'sd0},
			'{ 8'sd0,  8'sd0,   8'sd0,   8'sd0},
			'{ 8'sd3,  8'sd0,  -8'sd1,   8'sd2},
			'{ 8'sd6, -8'sd1,  -8'sd2,   8'sd4},
			'{ 8'sd9, -8'sd2,  -8'sd3,   8'sd7},
			'{ 8'sd12, -8'sd3, -8'sd4,   8'sd10},
			'{ 8'sd15, -8'sd4, -8'sd5,   8'sd12}
		},
		'{ // mid zone
			'{-8'sd5,  8'sd5,   8'sd5,  -8'sd5},
			'{-8'sd4,  8'sd4,   8'sd4,  -8'sd4},
			'{-8'sd2,  8'sd2,   8'sd2,  -8'sd2},
			'{-8'sd1,  8'sd1,   8'sd1,  -8'sd1},
			'{ 8'sd0,  8'sd0,   8'sd0,   8'sd0},
			'{ 8'sd1, -8'sd1,  -8'sd1,   8'sd1},
			'{ 8'sd2, -8'sd2,  -8'sd2,   8'sd2},
			'{ 8'sd3, -8'sd4,  -8'sd4,   8'sd4},
			'{ 8'sd4, -8'sd6,  -8'sd6,   8'sd5},
			'{ 8'sd5, -8'sd8,  -8'sd8,   8'sd7}
		},
		'{ // high zone
			'{-8'sd10, 8'sd0,   8'sd0,  -8'sd10},
			'{-8'sd7,  8'sd0,   8'sd0,  -8'sd7},
			'{-8'sd5,  8'sd0,   8'sd0,  -8'sd5},
			'{-8'sd2,  8'sd0,   8'sd0,  -8'sd2},
			'{ 8'sd0,  8'sd0,   8'sd0,   8'sd0},
			'{ 8'sd1, -8'sd2,  -8'sd2,   8'sd1},
			'{ 8'sd1, -8'sd4,  -8'sd4,   8'sd1},
			'{ 8'sd2, -8'sd6,  -8'sd6,   8'sd2},
			'{ 8'sd3, -8'sd8,  -8'sd8,   8'sd3},
			'{ 8'sd4, -8'sd10, -8'sd10,  8'sd4}
		}
	};

endpackage

/* rtl/attitude_offset_top.sv */
`timescale 1ns/1ps

module attitude_offset_top
	import flight_pkg::*;
(
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [STICK_W-1:0]                   throttle,
	input  logic [STICK_W-1:0]                   pitch,
	input  logic [STICK_W-1:0]                   roll,
	output logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  motor_thr,
	output logic [NUM_LEDS-1:0]                  leds,
	output logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  motor_pitch,
	output logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  motor_roll
);

	logic [2:0]                           thr_band;
	logic                                 attitude_active;
	logic [ZONE_IDX_W-1:0]                zone;
	logic [BAND_IDX_W-1:0]                pitch_band;
	logic [BAND_IDX_W-1:0]                roll_band;
	logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  thr_next;
	logic [NUM_LEDS-1:0]                  led_next;
	logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  pitch_next;
	logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  roll_next;

	stick_band_decoder i_decoder (
		.throttle        (throttle),
		.pitch           (pitch),
		.roll            (roll),
		.thr_band        (thr_band),
		.attitude_active (attitude_active),
		.zone            (zone),
		.pitch_band      (pitch_band),
		.roll_band       (roll_band)
	);

	mix_table_lookup i_lookup (
		.throttle   (throttle),
		.thr_band   (thr_band),
		.zone       (zone),
		.pitch_band (pitch_band),
		.roll_band  (roll_band),
		.thr_next   (thr_next),
		.led_next   (led_next),
		.pitch_next (pitch_next),
		.roll_next  (roll_next)
	);

	offset_output_reg i_out_reg (
		.clk             (clk),
		.rst_n           (rst_n),
		.attitude_active (attitude_active),
		.thr_next        (thr_next),
		.led_next        (led_next),
		.pitch_next      (pitch_next),
		.roll_next       (roll_next),
		.motor_thr       (motor_thr),
		.leds            (leds),
		.motor_pitch     (motor_pitch),
		.motor_roll      (motor_roll)
	);

endmodule

/* rtl/mix_table_lookup.sv */
`timescale 1ns/1ps

module mix_table_lookup
	import flight_pkg::*;
(
	input  logic [STICK_W-1:0]                   throttle,
	input  logic [2:0]                           thr_band,
	input  logic [ZONE_IDX_W-1:0]                zone,
	input  logic [BAND_IDX_W-1:0]                pitch_band,
	input  logic [BAND_IDX_W-1:0]                roll_band,
	output logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  thr_next,
	output logic [NUM_LEDS-1:0]                  led_next,
	output logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  pitch_next,
	output logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  roll_next
);

	// per motor base add wraps at 8 bits
	always_comb
	begin
		for (int m = 0; m < NUM_MOTORS; m++)
		begin
			thr_next[m] = throttle + THR_BASE_ADD[thr_band][m];
		end
	end

	assign led_next = LED_PATTERN[thr_band];

	// two's complement corrections pass through as raw bytes
	always_comb
	begin
		for (int m = 0; m < NUM_MOTORS; m++)
		begin
			pitch_next[m] = PITCH_CORR[zone][pitch_band][m];
			roll_next[m]  = ROLL_CORR[zone][roll_band][m];
		end
	end

endmodule

/* rtl/offset_output_reg.sv */
`timescale 1ns/1ps

module offset_output_reg
	import flight_pkg::*;
(
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 attitude_active,
	input  logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  thr_next,
	input  logic [NUM_LEDS-1:0]                  led_next,
	input  logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  pitch_next,
	input  logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  roll_next,
	output logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  motor_thr,
	output logic [NUM_LEDS-1:0]                  leds,
	output logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  motor_pitch,
	output logic [NUM_MOTORS-1:0][OFFSET_W-1:0]  motor_roll
);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			motor_thr <= '0;
			leds      <= '0;
		end
		else
		begin
			motor_thr <= thr_next;
			leds      <= led_next;
		end
	end

	// at idle throttle the last attitude correction is kept
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			motor_pitch <= '0;
			motor_roll  <= '0;
		end
		else if (attitude_active)
		begin
			motor_pitch <= pitch_next;
			motor_roll  <= roll_next;
		end
	end

endmodule

/* rtl/stick_band_decoder.sv */
`timescale 1ns/1ps

module stick_band_decoder
	import flight_pkg::*;
(
	input  logic [STICK_W-1:0]    throttle,
	input  logic [STICK_W-1:0]    pitch,
	input  logic [STICK_W-1:0]    roll,
	output logic [2:0]            thr_band,
	output logic                  attitude_active,
	output logic [ZONE_IDX_W-1:0] zone,
	output logic [BAND_IDX_W-1:0] pitch_band,
	output logic [BAND_IDX_W-1:0] roll_band
);

	// limits are ascending, so the band is the count of limits below the value
	function automatic logic [BAND_IDX_W-1:0] stick_band(input logic [STICK_W-1:0] val);
		logic [BAND_IDX_W-1:0] band;
		band = '0;
		for (int i = 0; i < NUM_STICK_BANDS - 1; i++)
		begin
			if (val > STICK_LIMITS[i])
				band = band + 4'd1;
		end
		return band;
	endfunction

	always_comb
	begin
		thr_band = '0;
		for (int i = 0; i < NUM_THR_BANDS - 1; i++)
		begin
			if (throttle > THR_BAND_LIMITS[i])
				thr_band = thr_band + 3'd1;
		end
	end

	// zone below idle reads as low and the output register ignores it
	always_comb
	begin
		zone = '0;
		for (int i = 0; i < NUM_ZONES - 1; i++)
		begin
			if (throttle > ZONE_LIMITS[i])
				zone = zone + 2'd1;
		end
	end

	assign attitude_active = (throttle > ZONE_IDLE_MAX);

	assign pitch_band = stick_band(pitch);
	assign roll_band  = stick_band(roll);

endmodule

/* verif/attitude_offset_properties.sv */
`timescale 1ns/1ps

module attitude_offset_properties
	import flight_pkg::*;
(
	input logic                                clk,
	input logic                                rst_n,
	input logic                                attitude_active,
	input logic [NUM_MOTORS-1:0][OFFSET_W-1:0] motor_thr,
	input logic [NUM_LEDS-1:0]                 leds,
	input logic [NUM_MOTORS-1:0][OFFSET_W-1:0] motor_pitch,
	input logic [NUM_MOTORS-1:0][OFFSET_W-1:0] motor_roll
);

	logic out_valid; // set once an edge with rst_n high has loaded the outputs
	logic led_ok;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= 1'b1;
	end

	always_comb
	begin
		led_ok = 1'b0;
		for (int i = 0; i < NUM_THR_BANDS; i++)
		begin
			if (leds == LED_PATTERN[i])
				led_ok = 1'b1;
		end
	end

	a_reset_zero: assert property (@(posedge clk) !rst_n |->
		(motor_thr == '0 && leds == '0 && motor_pitch == '0 && motor_roll == '0))
		else $error("outputs not cleared while rst_n is low");

	a_led_word: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> led_ok)
		else $error("leds hold a word outside the LED table");

	// idle throttle freezes the attitude outputs
	a_attitude_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!attitude_active |=> ($stable(motor_pitch) && $stable(motor_roll)))
		else $error("pitch or roll changed on an idle throttle edge");

endmodule

bind attitude_offset_top attitude_offset_properties i_props (
	.clk             (clk),
	.rst_n           (rst_n),
	.attitude_active (attitude_active),
	.motor_thr       (motor_thr),
	.leds            (leds),
	.motor_pitch     (motor_pitch),
	.motor_roll      (motor_roll)
);

/* verif/tb_attitude_offset.sv */
`timescale 1ns/1ps

module tb_attitude_offset
	import flight_pkg::*;
();

	localparam time CLK_PERIOD = 100;

	logic                                clk = 1'b0;
	logic                                rst_n = 1'b1;
	logic [STICK_W-1:0]                  throttle;
	logic [STICK_W-1:0]                  pitch;
	logic [STICK_W-1:0]                  roll;
	logic [NUM_MOTORS-1:0][OFFSET_W-1:0] motor_thr;
	logic [NUM_LEDS-1:0]                 leds;
	logic [NUM_MOTORS-1:0][OFFSET_W-1:0] motor_pitch;
	logic [NUM_MOTORS-1:0][OFFSET_W-1:0] motor_roll;

	// model state that mirrors what the output register should hold
	logic [NUM_MOTORS-1:0][OFFSET_W-1:0] exp_thr;
	logic [NUM_LEDS-1:0]                 exp_leds;
	logic [NUM_MOTORS-1:0][OFFSET_W-1:0] exp_pitch;
	logic [NUM_MOTORS-1:0][OFFSET_W-1:0] exp_roll;
	logic [STICK_W-1:0]                  cur_thr;
	logic [STICK_W-1:0]                  cur_pitch;
	logic [STICK_W-1:0]                  cur_roll;

	int     err_cnt = 0;
	int     timeout_cnt = 0;
	int     check_cnt = 0;
	integer seed = 32'hed92;

	attitude_offset_top i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.throttle    (throttle),
		.pitch       (pitch),
		.roll        (roll),
		.motor_thr   (motor_thr),
		.leds        (leds),
		.motor_pitch (motor_pitch),
		.motor_roll  (motor_roll)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// lowest band whose limit is not exceeded or else the top band
	function automatic logic [2:0] thr_band_of(input logic [STICK_W-1:0] t);
		logic [2:0] band;
		band = 3'(NUM_THR_BANDS - 1);
		for (int i = NUM_THR_BANDS - 2; i >= 0; i--)
		begin
			if (t <= THR_BAND_LIMITS[i])
				band = 3'(i);
		end
		return band;
	endfunction

	function automatic logic [ZONE_IDX_W-1:0] zone_of(input logic [STICK_W-1:0] t);
		logic [ZONE_IDX_W-1:0] z;
		z = ZONE_IDX_W'(NUM_ZONES - 1);
		for (int i = NUM_ZONES - 2; i >= 0; i--)
		begin
			if (t <= ZONE_LIMITS[i])
				z = ZONE_IDX_W'(i);
		end
		return z;
	endfunction

	function automatic logic [BAND_IDX_W-1:0] stick_band_of(input logic [STICK_W-1:0] s);
		logic [BAND_IDX_W-1:0] band;
		band = BAND_IDX_W'(NUM_STICK_BANDS - 1);
		for (int i = NUM_STICK_BANDS - 2; i >= 0; i--)
		begin
			if (s <= STICK_LIMITS[i])
				band = BAND_IDX_W'(i);
		end
		return band;
	endfunction

	task automatic wait_rise(input int n);
		int  seen;
		time deadline;
		seen = 0;
		deadline = $time + time'(n) * CLK_PERIOD;
		while (seen < n && $time <= deadline)
		begin
			@(posedge clk);
			seen++;
		end
		if (seen < n || $time > deadline)
		begin
			timeout_cnt++;
			$display("timeout: %0d rising clock edges did not arrive in time", n);
		end
	endtask

	task automatic wait_fall(input int n);
		int  seen;
		time deadline;
		seen = 0;
		deadline = $time + time'(n) * CLK_PERIOD;
		while (seen < n && $time <= deadline)
		begin
			@(negedge clk);
			seen++;
		end
		if (seen < n || $time > deadline)
		begin
			timeout_cnt++;
			$display("timeout: %0d falling clock edges did not arrive in time", n);
		end
	endtask

	task automatic check_motor_vec(input string name,
		input logic [NUM_MOTORS-1:0][OFFSET_W-1:0] expected,
		input logic [NUM_MOTORS-1:0][OFFSET_W-1:0] actual);
		check_cnt++;
		if (actual !== expected)
		begin
			err_cnt++;
			$display("ERROR %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic check_leds(input logic [NUM_LEDS-1:0] expected,
		input logic [NUM_LEDS-1:0] actual);
		check_cnt++;
		if (actual !== expected)
		begin
			err_cnt++;
			$display("ERROR leds expected 0x%h actual 0x%h at %0t", expected, actual, $time);
		end
	endtask

	task automatic check_all();
		check_motor_vec("motor_thr", exp_thr, motor_thr);
		check_leds(exp_leds, leds);
		check_motor_vec("motor_pitch", exp_pitch, motor_pitch);
		check_motor_vec("motor_roll", exp_roll, motor_roll);
	endtask

	// what the register should take at this edge from the inputs in place
	task automatic model_edge();
		logic [2:0]            tband;
		logic [ZONE_IDX_W-1:0] z;
		logic [BAND_IDX_W-1:0] pb;
		logic [BAND_IDX_W-1:0] rb;
		tband = thr_band_of(cur_thr);
		z = zone_of(cur_thr);
		pb = stick_band_of(cur_pitch);
		rb = stick_band_of(cur_roll);
		for (int m = 0; m < NUM_MOTORS; m++)
			exp_thr[m] = cur_thr + THR_BASE_ADD[tband][m]; // wraps at 8 bits
		exp_leds = LED_PATTERN[tband];
		if (cur_thr > ZONE_IDLE_MAX)
		begin
			for (int m = 0; m < NUM_MOTORS; m++)
			begin
				exp_pitch[m] = PITCH_CORR[z][pb][m];
				exp_roll[m]  = ROLL_CORR[z][rb][m];
			end
		end
	endtask

	// one clock per call that checks the inputs of the previous call
	task automatic step(input logic [STICK_W-1:0] t, input logic [STICK_W-1:0] p,
		input logic [STICK_W-1:0] r);
		wait_rise(1);
		model_edge();
		throttle <= t;
		pitch    <= p;
		roll     <= r;
		cur_thr   = t;
		cur_pitch = p;
		cur_roll  = r;
		wait_fall(1);
		check_all();
	endtask

	task automatic hold_inputs();
		step(cur_thr, cur_pitch, cur_roll);
	endtask

	task automatic reset_test();
		throttle = '0;
		pitch    = '0;
		roll     = '0;
		cur_thr   = '0;
		cur_pitch = '0;
		cur_roll  = '0;
		exp_thr   = '0;
		exp_leds  = '0;
		exp_pitch = '0;
		exp_roll  = '0;
		rst_n <= 1'b0;
		wait_fall(1);
		check_all();
		wait_rise(2); // third edge under reset
		rst_n <= 1'b1;
		wait_fall(1);
		check_all();
	endtask

	task automatic throttle_sweep();
		logic [STICK_W-1:0] vals [10] = '{8'd0, 8'd2, 8'd3, 8'd10, 8'd11,
			8'd20, 8'd21, 8'd30, 8'd31, 8'd250};
		for (int i = 0; i < 10; i++)
			step(vals[i], cur_pitch, cur_roll);
		hold_inputs();
	endtask

	// on_roll selects which stick is stepped over the band edges
	task automatic corr_sweep(input bit on_roll);
		logic [STICK_W-1:0] zone_thr [NUM_ZONES] = '{8'd8, 8'd20, 8'd40};
		logic [STICK_W-1:0] lo;
		logic [STICK_W-1:0] hi;
		for (int z = 0; z < NUM_ZONES; z++)
		begin
			for (int b = 0; b < NUM_STICK_BANDS; b++)
			begin
				lo = (b == 0) ? 8'd0 : STICK_LIMITS[b-1] + 8'd1;
				hi = (b == NUM_STICK_BANDS - 1) ? 8'd255 : STICK_LIMITS[b];
				if (on_roll)
				begin
					step(zone_thr[z], cur_pitch, lo);
					step(zone_thr[z], cur_pitch, hi);
				end
				else
				begin
					step(zone_thr[z], lo, cur_roll);
					step(zone_thr[z], hi, cur_roll);
				end
			end
		end
		hold_inputs();
	endtask

	task automatic idle_hold_test();
		logic [NUM_MOTORS-1:0][OFFSET_W-1:0] held_pitch;
		logic [NUM_MOTORS-1:0][OFFSET_W-1:0] held_roll;
		step(8'd20, 8'd40, 8'd0);
		step(8'd4, 8'd12, 8'd33);
		held_pitch = exp_pitch;
		held_roll  = exp_roll;
		if (held_pitch == '0 || held_roll == '0)
		begin
			err_cnt++;
			$display("hold test setup did not produce nonzero pitch and roll corrections");
		end
		step(8'd3, 8'd0, 8'd50);
		step(8'd0, 8'd25, 8'd7);
		hold_inputs();
		check_motor_vec("motor_pitch", held_pitch, motor_pitch);
		check_motor_vec("motor_roll", held_roll, motor_roll);
	endtask

	task automatic random_sweep();
		logic [31:0]        r;
		logic [STICK_W-1:0] t;
		for (int i = 0; i < 200; i++)
		begin
			r = $random(seed);
			t = r[8] ? (r[7:0] % 8'd48) : r[7:0]; // favour the low zones and idle
			step(t, {2'b00, r[21:16]}, {2'b00, r[29:24]});
		end
		hold_inputs();
	endtask

	initial
	begin
		reset_test();
		throttle_sweep();
		corr_sweep(1'b0);
		corr_sweep(1'b1);
		idle_hold_test();
		random_sweep();
		$display("checks %0d, errors %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
